// File: verilog/fft16_pkg.sv
`default_nettype none

package fft16_pkg;

  ////////////////////////////////////////
  // Transform shape
  ////////////////////////////////////////

  localparam int N_POINTS = 16;
  localparam int RADIX    = 4;

  ////////////////////////////////////////
  // Twiddle coefficients, Q1.14
  ////////////////////////////////////////

  localparam int TW_FRAC = 14;
  localparam int TW_W    = 16;

  // Real part of W16^e, cos(2*pi*e/16)
  localparam logic signed [TW_W-1:0] TW_RE [10] = '{
    16'sd16384,  16'sd15137,  16'sd11585,  16'sd6270,   16'sd0,
    -16'sd6270, -16'sd11585, -16'sd15137, -16'sd16384, -16'sd15137
  };

  // Imaginary part of W16^e, -sin(2*pi*e/16)
  localparam logic signed [TW_W-1:0] TW_IM [10] = '{
    16'sd0,     -16'sd6270,  -16'sd11585, -16'sd15137, -16'sd16384,
    -16'sd15137, -16'sd11585, -16'sd6270,  16'sd0,      16'sd6270
  };

endpackage

`default_nettype wire

// File: verilog/dft4.sv
`timescale 1ns/1ns
`default_nettype none

module dft4 #(
  parameter int W = 14
) (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                en_i,
  input  logic signed [W-1:0] a_re_i,
  input  logic signed [W-1:0] a_im_i,
  input  logic signed [W-1:0] b_re_i,
  input  logic signed [W-1:0] b_im_i,
  input  logic signed [W-1:0] c_re_i,
  input  logic signed [W-1:0] c_im_i,
  input  logic signed [W-1:0] d_re_i,
  input  logic signed [W-1:0] d_im_i,
  output logic signed [W+1:0] y0_re_o,
  output logic signed [W+1:0] y0_im_o,
  output logic signed [W+1:0] y1_re_o,
  output logic signed [W+1:0] y1_im_o,
  output logic signed [W+1:0] y2_re_o,
  output logic signed [W+1:0] y2_im_o,
  output logic signed [W+1:0] y3_re_o,
  output logic signed [W+1:0] y3_im_o
);

  // Operands widen to W+2 before the sums, so nothing overflows
  always_ff @(posedge clk) begin
    if (rst_i) begin
      y0_re_o <= '0;
      y0_im_o <= '0;
      y1_re_o <= '0;
      y1_im_o <= '0;
      y2_re_o <= '0;
      y2_im_o <= '0;
      y3_re_o <= '0;
      y3_im_o <= '0;
    end else if (en_i) begin
      y0_re_o <= a_re_i + b_re_i + c_re_i + d_re_i;
      y0_im_o <= a_im_i + b_im_i + c_im_i + d_im_i;
      // a - jb - c + jd
      y1_re_o <= a_re_i + b_im_i - c_re_i - d_im_i;
      y1_im_o <= a_im_i - b_re_i - c_im_i + d_re_i;
      y2_re_o <= a_re_i - b_re_i + c_re_i - d_re_i;
      y2_im_o <= a_im_i - b_im_i + c_im_i - d_im_i;
      // a + jb - c - jd
      y3_re_o <= a_re_i - b_im_i - c_re_i + d_im_i;
      y3_im_o <= a_im_i + b_re_i - c_im_i - d_re_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/twiddle_mult.sv
`timescale 1ns/1ns
`default_nettype none

module twiddle_mult #(
  parameter int W   = 14,
  parameter int EXP = 1
) (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                en_i,
  input  logic signed [W-1:0] x_re_i,
  input  logic signed [W-1:0] x_im_i,
  output logic signed [W:0]   y_re_o,
  output logic signed [W:0]   y_im_o
);

  localparam logic signed [fft16_pkg::TW_W-1:0] C_RE = fft16_pkg::TW_RE[EXP];
  localparam logic signed [fft16_pkg::TW_W-1:0] C_IM = fft16_pkg::TW_IM[EXP];

  // Full product width plus one bit for the sum
  localparam int PW = W + fft16_pkg::TW_W + 1;

  logic signed [PW-1:0] acc_re;
  logic signed [PW-1:0] acc_im;

  always_comb begin
    acc_re = x_re_i * C_RE - x_im_i * C_IM;
    acc_im = x_re_i * C_IM + x_im_i * C_RE;
  end

  // Floor by arithmetic shift; |W16^e| <= 1 keeps the result in W+1 bits
  always_ff @(posedge clk) begin
    if (rst_i) begin
      y_re_o <= '0;
      y_im_o <= '0;
    end else if (en_i) begin
      y_re_o <= (W+1)'(acc_re >>> fft16_pkg::TW_FRAC);
      y_im_o <= (W+1)'(acc_im >>> fft16_pkg::TW_FRAC);
    end
  end

endmodule

`default_nettype wire

// File: verilog/fft16_core.sv
`timescale 1ns/1ns
`default_nettype none

module fft16_core #(
  parameter int IN_W  = 12,
  parameter int OUT_W = IN_W + 5
) (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   frame_valid_i,
  input  logic signed [IN_W-1:0] frame_re_i [fft16_pkg::N_POINTS],
  input  logic signed [IN_W-1:0] frame_im_i [fft16_pkg::N_POINTS],
  output logic                   frame_advance_o,
  input  logic                   sink_ready_i,
  output logic                   bins_valid_o,
  output wire signed [OUT_W-1:0] bins_re_o [fft16_pkg::N_POINTS],
  output wire signed [OUT_W-1:0] bins_im_o [fft16_pkg::N_POINTS]
);

  localparam int R    = fft16_pkg::RADIX;
  localparam int N    = fft16_pkg::N_POINTS;
  localparam int S1_W = IN_W + 2;
  localparam int S2_W = OUT_W - 2;

  // Indexed n2*R + k1
  wire signed [S1_W-1:0] s1_re [N];
  wire signed [S1_W-1:0] s1_im [N];
  wire signed [S2_W-1:0] s2_re [N];
  wire signed [S2_W-1:0] s2_im [N];

  logic v1;
  logic v2;
  logic v3;

  // Whole pipe moves together; it only waits on a full last register
  assign frame_advance_o = !v3 || sink_ready_i;
  assign bins_valid_o    = v3;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
      v3 <= 1'b0;
    end else if (frame_advance_o) begin
      v1 <= frame_valid_i;
      v2 <= v1;
      v3 <= v2;
    end
  end

  ////////////////////////////////////////
  // Stage 1, DFT over n1 for each n2
  ////////////////////////////////////////

  for (genvar n2 = 0; n2 < R; n2++) begin : g_stage1
    dft4 #(.W(IN_W)) u_dft (
      .clk(clk), .rst_i(rst_i), .en_i(frame_advance_o),
      .a_re_i(frame_re_i[n2]),       .a_im_i(frame_im_i[n2]),
      .b_re_i(frame_re_i[R + n2]),   .b_im_i(frame_im_i[R + n2]),
      .c_re_i(frame_re_i[2*R + n2]), .c_im_i(frame_im_i[2*R + n2]),
      .d_re_i(frame_re_i[3*R + n2]), .d_im_i(frame_im_i[3*R + n2]),
      .y0_re_o(s1_re[n2*R]),     .y0_im_o(s1_im[n2*R]),
      .y1_re_o(s1_re[n2*R + 1]), .y1_im_o(s1_im[n2*R + 1]),
      .y2_re_o(s1_re[n2*R + 2]), .y2_im_o(s1_im[n2*R + 2]),
      .y3_re_o(s1_re[n2*R + 3]), .y3_im_o(s1_im[n2*R + 3])
    );
  end

  ////////////////////////////////////////
  // Twiddle bank, W16^(n2*k1)
  ////////////////////////////////////////

  for (genvar n2 = 0; n2 < R; n2++) begin : g_tw_row
    for (genvar k1 = 0; k1 < R; k1++) begin : g_tw_col
      localparam int I = n2 * R + k1;
      if (n2 * k1 == 0) begin : g_pass
        logic signed [S2_W-1:0] d_re;
        logic signed [S2_W-1:0] d_im;
        // Unity twiddle, delay only
        always_ff @(posedge clk) begin
          if (frame_advance_o) begin
            d_re <= s1_re[I];
            d_im <= s1_im[I];
          end
        end
        assign s2_re[I] = d_re;
        assign s2_im[I] = d_im;
      end else begin : g_mult
        twiddle_mult #(.W(S1_W), .EXP(n2 * k1)) u_tw (
          .clk(clk), .rst_i(rst_i), .en_i(frame_advance_o),
          .x_re_i(s1_re[I]), .x_im_i(s1_im[I]),
          .y_re_o(s2_re[I]), .y_im_o(s2_im[I])
        );
      end
    end
  end

  ////////////////////////////////////////
  // Stage 2, DFT over n2 for each k1
  ////////////////////////////////////////

  for (genvar k1 = 0; k1 < R; k1++) begin : g_stage2
    // Bin k = k1 + R*k2
    dft4 #(.W(S2_W)) u_dft (
      .clk(clk), .rst_i(rst_i), .en_i(frame_advance_o),
      .a_re_i(s2_re[k1]),       .a_im_i(s2_im[k1]),
      .b_re_i(s2_re[R + k1]),   .b_im_i(s2_im[R + k1]),
      .c_re_i(s2_re[2*R + k1]), .c_im_i(s2_im[2*R + k1]),
      .d_re_i(s2_re[3*R + k1]), .d_im_i(s2_im[3*R + k1]),
      .y0_re_o(bins_re_o[k1]),       .y0_im_o(bins_im_o[k1]),
      .y1_re_o(bins_re_o[R + k1]),   .y1_im_o(bins_im_o[R + k1]),
      .y2_re_o(bins_re_o[2*R + k1]), .y2_im_o(bins_im_o[2*R + k1]),
      .y3_re_o(bins_re_o[3*R + k1]), .y3_im_o(bins_im_o[3*R + k1])
    );
  end

endmodule

`default_nettype wire

// File: verilog/sample_loader.sv
`timescale 1ns/1ns
`default_nettype none

module sample_loader #(
  parameter int IN_W = 12
) (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   in_valid_i,
  input  logic signed [IN_W-1:0] in_re_i,
  input  logic signed [IN_W-1:0] in_im_i,
  output logic                   in_ready_o,
  input  logic                   frame_advance_i,
  output logic                   frame_valid_o,
  output logic signed [IN_W-1:0] frame_re_o [fft16_pkg::N_POINTS],
  output logic signed [IN_W-1:0] frame_im_o [fft16_pkg::N_POINTS]
);

  logic [3:0] cnt;
  logic       full;
  logic       accept;

  assign in_ready_o    = !full;
  assign frame_valid_o = full;
  assign accept        = in_valid_i && !full;

  // Frame buffer, sample n at position n
  always_ff @(posedge clk) begin
    if (accept) begin
      frame_re_o[cnt] <= in_re_i;
      frame_im_o[cnt] <= in_im_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      cnt  <= '0;
      full <= 1'b0;
    end else if (accept) begin
      cnt <= cnt + 4'd1;
      if (cnt == 4'(fft16_pkg::N_POINTS - 1))
        full <= 1'b1;
    end else if (full && frame_advance_i) begin
      // Core took the frame this edge
      full <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/bin_unloader.sv
`timescale 1ns/1ns
`default_nettype none

module bin_unloader #(
  parameter int OUT_W = 17
) (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    bins_valid_i,
  input  logic signed [OUT_W-1:0] bins_re_i [fft16_pkg::N_POINTS],
  input  logic signed [OUT_W-1:0] bins_im_i [fft16_pkg::N_POINTS],
  output logic                    sink_ready_o,
  input  logic                    out_ready_i,
  output logic                    out_valid_o,
  output logic signed [OUT_W-1:0] out_re_o,
  output logic signed [OUT_W-1:0] out_im_o,
  output logic                    out_last_o
);

  logic signed [OUT_W-1:0] buf_re [fft16_pkg::N_POINTS];
  logic signed [OUT_W-1:0] buf_im [fft16_pkg::N_POINTS];
  logic [3:0]              idx;
  logic                    full;
  logic                    capture;
  logic                    beat;

  assign sink_ready_o = !full;
  assign capture      = bins_valid_i && !full;
  assign beat         = full && out_ready_i;

  assign out_valid_o = full;
  assign out_re_o    = buf_re[idx];
  assign out_im_o    = buf_im[idx];
  assign out_last_o  = full && (idx == 4'(fft16_pkg::N_POINTS - 1));

  always_ff @(posedge clk) begin
    if (capture) begin
      buf_re <= bins_re_i;
      buf_im <= bins_im_i;
    end
  end

  // Index wraps back to 0 after the last bin
  always_ff @(posedge clk) begin
    if (rst_i) begin
      idx  <= '0;
      full <= 1'b0;
    end else if (capture) begin
      full <= 1'b1;
    end else if (beat) begin
      idx <= idx + 4'd1;
      if (out_last_o)
        full <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/fft16_top.sv
`timescale 1ns/1ns
`default_nettype none

module fft16_top #(
  parameter int IN_W  = 12,
  parameter int OUT_W = IN_W + 5
) (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    in_valid_i,
  input  logic signed [IN_W-1:0]  in_re_i,
  input  logic signed [IN_W-1:0]  in_im_i,
  output logic                    in_ready_o,
  input  logic                    out_ready_i,
  output logic                    out_valid_o,
  output logic signed [OUT_W-1:0] out_re_o,
  output logic signed [OUT_W-1:0] out_im_o,
  output logic                    out_last_o
);

  ////////////////////////////////////////
  // Frame links
  ////////////////////////////////////////

  logic                   ld_frame_valid;
  logic signed [IN_W-1:0] ld_frame_re [fft16_pkg::N_POINTS];
  logic signed [IN_W-1:0] ld_frame_im [fft16_pkg::N_POINTS];
  logic                   core_advance;

  logic                   core_valid;
  wire signed [OUT_W-1:0] core_bins_re [fft16_pkg::N_POINTS];
  wire signed [OUT_W-1:0] core_bins_im [fft16_pkg::N_POINTS];
  logic                   unl_ready;

  sample_loader #(.IN_W(IN_W)) u_loader (
    .clk             (clk),
    .rst_i           (rst_i),
    .in_valid_i      (in_valid_i),
    .in_re_i         (in_re_i),
    .in_im_i         (in_im_i),
    .in_ready_o      (in_ready_o),
    .frame_advance_i (core_advance),
    .frame_valid_o   (ld_frame_valid),
    .frame_re_o      (ld_frame_re),
    .frame_im_o      (ld_frame_im)
  );

  fft16_core #(.IN_W(IN_W), .OUT_W(OUT_W)) u_core (
    .clk             (clk),
    .rst_i           (rst_i),
    .frame_valid_i   (ld_frame_valid),
    .frame_re_i      (ld_frame_re),
    .frame_im_i      (ld_frame_im),
    .frame_advance_o (core_advance),
    .sink_ready_i    (unl_ready),
    .bins_valid_o    (core_valid),
    .bins_re_o       (core_bins_re),
    .bins_im_o       (core_bins_im)
  );

  bin_unloader #(.OUT_W(OUT_W)) u_unloader (
    .clk          (clk),
    .rst_i        (rst_i),
    .bins_valid_i (core_valid),
    .bins_re_i    (core_bins_re),
    .bins_im_i    (core_bins_im),
    .sink_ready_o (unl_ready),
    .out_ready_i  (out_ready_i),
    .out_valid_o  (out_valid_o),
    .out_re_o     (out_re_o),
    .out_im_o     (out_im_o),
    .out_last_o   (out_last_o)
  );

endmodule

`default_nettype wire

// File: tests/tb_fft16.sv
`timescale 1ns/1ns
`default_nettype none

module tb_fft16;

  localparam int IN_W           = 12;
  localparam int OUT_W          = IN_W + 5;
  localparam int N_FRAMES       = 5;
  localparam int REC_WORDS      = 64;
  localparam int PASSES         = 2;
  localparam int TOTAL_BINS     = PASSES * N_FRAMES * 16;
  localparam int TIMEOUT_CYCLES = 200 * PASSES * N_FRAMES + 100;

  logic             clk;
  logic             rst;
  logic             in_valid;
  logic [IN_W-1:0]  in_re;
  logic [IN_W-1:0]  in_im;
  logic             in_ready;
  logic             out_ready;
  logic             out_valid;
  logic [OUT_W-1:0] out_re;
  logic [OUT_W-1:0] out_im;
  logic             out_last;

  // Per frame 32 input words, then 32 expected words, re/im interleaved
  logic [OUT_W-1:0] trace_mem [N_FRAMES*REC_WORDS];

  int errors       = 0;
  int checks       = 0;
  int samples_sent = 0;
  int bins_seen    = 0;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  fft16_top #(.IN_W(IN_W), .OUT_W(OUT_W)) UUT (
    .clk         (clk),
    .rst_i       (rst),
    .in_valid_i  (in_valid),
    .in_re_i     (in_re),
    .in_im_i     (in_im),
    .in_ready_o  (in_ready),
    .out_ready_i (out_ready),
    .out_valid_o (out_valid),
    .out_re_o    (out_re),
    .out_im_o    (out_im),
    .out_last_o  (out_last)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  ////////////////////////////////////////
  // Input side
  ////////////////////////////////////////

  // Valid and data hold until the loader takes the sample
  task automatic send_sample(input logic [IN_W-1:0] re, input logic [IN_W-1:0] im);
    in_valid = 1'b1;
    in_re    = re;
    in_im    = im;
    while (!in_ready)
      @(negedge clk);
    @(negedge clk);
    samples_sent++;
  endtask

  task automatic drive_frames(input bit gaps);
    int base;
    int gap;
    for (int f = 0; f < N_FRAMES; f++) begin
      base = f * REC_WORDS;
      for (int n = 0; n < 16; n++) begin
        if (gaps && ($urandom % 4 == 0)) begin
          in_valid = 1'b0;
          gap = 1 + $urandom % 3;
          repeat (gap) @(negedge clk);
        end
        send_sample(trace_mem[base + 2*n][IN_W-1:0], trace_mem[base + 2*n + 1][IN_W-1:0]);
      end
    end
    in_valid = 1'b0;
  endtask

  ////////////////////////////////////////
  // Output side
  ////////////////////////////////////////

  // Outputs only move on rising edges, so the low phase is a safe place to look
  task automatic watch_output();
    int base;
    int k;
    bit holding;
    logic [OUT_W-1:0] held_re;
    logic [OUT_W-1:0] held_im;
    logic held_last;
    holding = 1'b0;
    forever begin
      @(negedge clk);
      if (holding) begin
        check_value("out_valid_o", out_valid, 1'b1);
        check_value("out_re_o", out_re, held_re);
        check_value("out_im_o", out_im, held_im);
        check_value("out_last_o", out_last, held_last);
      end
      // First pass and the final drain run at full rate
      if (bins_seen < N_FRAMES * 16 || bins_seen >= TOTAL_BINS)
        out_ready = 1'b1;
      else
        out_ready = ($urandom % 3 != 0);
      holding   = out_valid && !out_ready;
      held_re   = out_re;
      held_im   = out_im;
      held_last = out_last;
      if (out_valid && out_ready) begin
        base = ((bins_seen / 16) % N_FRAMES) * REC_WORDS + 32;
        k    = bins_seen % 16;
        check_value("out_re_o", out_re, trace_mem[base + 2*k]);
        check_value("out_im_o", out_im, trace_mem[base + 2*k + 1]);
        check_value("out_last_o", out_last, (k == 15));
        bins_seen++;
      end
    end
  endtask

  initial watch_output();

  initial begin
    void'($urandom(32'hf72abc75));
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_re     = '0;
    in_im     = '0;
    out_ready = 1'b0;
    $readmemh("tests/fft16_trace.txt", trace_mem);
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_value("out_valid_o", out_valid, 1'b0);
    check_value("out_last_o", out_last, 1'b0);
    check_value("in_ready_o", in_ready, 1'b1);
    drive_frames(1'b0);
    drive_frames(1'b1);
    wait (bins_seen == TOTAL_BINS);
    // Quiet period, long enough for any stray frame to reach the output
    repeat (8) @(negedge clk);
    check_value("out_valid_o", out_valid, 1'b0);
    check_value("bins out vs samples in", bins_seen, samples_sent);
    $display("Checks: %0d, errors: %0d, samples in: %0d, bins out: %0d",
             checks, errors, samples_sent, bins_seen);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: only %0d of %0d bins came out within %0d cycles",
             bins_seen, TOTAL_BINS, TIMEOUT_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/fft16_trace.txt
// Two lines per frame. Inputs: x0.re x0.im .. x15.re x15.im, 12-bit hex
// Expected: X0.re X0.im .. X15.re X15.im, 17-bit hex, natural bin order
// Impulse at n=0
7FF 800 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
007FF 1F800 007FF 1F800 007FF 1F800 007FF 1F800 007FF 1F800 007FF 1F800 007FF 1F800 007FF 1F800 007FF 1F800 007FF 1F800 007FF 1F800 007FF 1F800 007FF 1F800 007FF 1F800 007FF 1F800 007FF 1F800
// Constant frame
800 7FF 800 7FF 800 7FF 800 7FF 800 7FF 800 7FF 800 7FF 800 7FF 800 7FF 800 7FF 800 7FF 800 7FF 800 7FF 800 7FF 800 7FF 800 7FF
18000 07FF0 00000 00000 00000 00000 00000 00000 00000 00000 00000 00000 00000 00000 00000 00000 00000 00000 00000 00000 00000 00000 00000 00000 00000 00000 00000 00000 00000 00000 00000 00000
// Sample at n=1, twiddles 1 2 3
000 000 6C3 A86 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
006C3 1FA86 00426 1F85A 000E8 1F758 1FD87 1F7A8 1FA86 1F93D 1F85A 1FBDA 1F758 1FF18 1F7A8 00279 1F93D 0057A 1FBDA 007A6 1FF18 008A8 00279 00858 0057A 006C3 007A6 00426 008A8 000E8 00858 1FD87
// Sample at n=6, twiddles 2 4 6
000 000 000 000 000 000 000 000 000 000 000 000 831 36D 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
1F831 0036D 007F1 00319 1FC93 1F831 1FCE6 007F1 007CF 1FC93 1F80F 1FCE7 0036D 007CF 0031A 1F80F 1F831 0036D 007F1 00319 1FC93 1F831 1FCE6 007F1 007CF 1FC93 1F80F 1FCE7 0036D 007CF 0031A 1F80F
// Sample at n=11, twiddles 3 6 9
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 4D2 7FF 000 000 000 000 000 000 000 000
004D2 007FF 1F6C4 00164 0023E 1F6F0 00783 0058A 1F801 004D2 1FE9C 1F6C4 00910 0023E 1FA76 00783 1FB2E 1F801 0093C 1FE9C 1FDC2 00910 1F87D 1FA76 007FF 1FB2E 00164 0093C 1F6F0 1FDC2 0058A 1F87D

// File: filelist.f
verilog/fft16_pkg.sv
verilog/dft4.sv
verilog/twiddle_mult.sv
verilog/fft16_core.sv
verilog/sample_loader.sv
verilog/bin_unloader.sv
verilog/fft16_top.sv
tests/tb_fft16.sv

// File: run_sim.sh
#!/bin/sh
# Build the FFT testbench with Verilator, run it, and grade the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_fft16 \
  -o sim_fft16 > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_fft16 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST RESULT: PASS" sim.log; then
  exit 0
fi
exit 1
